/* design/shifter_pkg.sv */
`default_nettype none

package shifter_pkg;

    // Switch word and shifter result width
    localparam int DATA_W = 16;

    // One shamt bit per shifter stage
    localparam int SHAMT_W = 4;

    // Dir, rotate, shamt bit 0, shamt bit 1, shamt high increment
    localparam int BTN_COUNT = 5;

    // Encoding is {rotate, dir} so toggles map straight onto it
    typedef enum logic [1:0] {
        SHIFT_RIGHT  = 2'b00,
        SHIFT_LEFT   = 2'b01,
        ROTATE_RIGHT = 2'b10,
        ROTATE_LEFT  = 2'b11
    } shift_op_e;

endpackage

`default_nettype wire

/* design/display_pkg.sv */
`default_nettype none

package display_pkg;

    // Anodes on the board
    localparam int DIGITS = 8;

    // Digits that carry a result nibble
    localparam int SHOWN_DIGITS = 4;

    // Segments a to g
    localparam int SEG_W = 7;

    // Bits per displayed hex digit
    localparam int NIBBLE_W = 4;

    // Both buses are active low
    localparam logic [SEG_W-1:0]  SEG_BLANK = '1;
    localparam logic [DIGITS-1:0] AN_OFF    = '1;

endpackage

`default_nettype wire

/* design/tick_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_divider #(
    parameter int TICK_DIV = 100000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= RELOAD;                 // Period restarts on the pulse
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/button_debounce.sv */
`timescale 1ns/10ps
`default_nettype none

module button_debounce #(
    parameter int DEBOUNCE_TICKS = 10
) (
    input  logic clk,
    input  logic rst_n,
    input  logic tick,
    input  logic btn_raw,
    output logic press,
    output logic toggled
);

    localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DEBOUNCE_TICKS - 1);

    typedef enum logic [1:0] {
        RELEASED,
        PRESS_WAIT,
        PRESSED,
        RELEASE_WAIT
    } state_e;

    state_e           state;
    logic [1:0]       sync;
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync       <= 2'b00;
            state      <= RELEASED;
            stable_cnt <= '0;
            press      <= 1'b0;
            toggled    <= 1'b0;
        end else begin
            sync  <= {sync[0], btn_raw};    // Two-flop synchronizer
            press <= 1'b0;
            if (tick) begin
                case (state)
                    RELEASED: begin
                        if (sync[1]) begin
                            state      <= PRESS_WAIT;
                            stable_cnt <= CNT_W'(1);   // First high sample
                        end
                    end
                    PRESS_WAIT: begin
                        if (!sync[1]) begin
                            state <= RELEASED;           // Bounce, start over
                        end else if (stable_cnt == LAST) begin
                            state   <= PRESSED;
                            press   <= 1'b1;
                            toggled <= ~toggled;
                        end else begin
                            stable_cnt <= stable_cnt + 1'b1;
                        end
                    end
                    PRESSED: begin
                        if (!sync[1]) begin
                            state      <= RELEASE_WAIT;
                            stable_cnt <= CNT_W'(1);
                        end
                    end
                    default: begin
                        if (sync[1]) begin
                            state <= PRESSED;            // Still held, no new press
                        end else if (stable_cnt == LAST) begin
                            state <= RELEASED;
                        end else begin
                            stable_cnt <= stable_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/shift_control.sv */
`timescale 1ns/10ps
`default_nettype none

module shift_control #(
    parameter int DEBOUNCE_TICKS = 10
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              tick,
    input  logic [shifter_pkg::BTN_COUNT-1:0] btn,
    output shifter_pkg::shift_op_e            op,
    output logic [shifter_pkg::SHAMT_W-1:0]   shamt
);

    localparam int BTN_DIR = 0;
    localparam int BTN_ROT = 1;
    localparam int BTN_SH0 = 2;
    localparam int BTN_SH1 = 3;
    localparam int BTN_INC = 4;
    localparam int HI_W    = shifter_pkg::SHAMT_W - 2;

    logic [BTN_INC-1:0]     toggled;
    logic                   inc_press;
    logic [HI_W-1:0]        hi_cnt;
    logic [HI_W-1:0]        hi_next;
    shifter_pkg::shift_op_e op_next;

    // Buttons 0 to 3 act as toggles
    for (genvar i = 0; i < BTN_INC; i++) begin : g_toggle
        button_debounce #(
            .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
        ) u_debounce (
            .clk    (clk),
            .rst_n  (rst_n),
            .tick   (tick),
            .btn_raw(btn[i]),
            .press  (),
            .toggled(toggled[i])
        );
    end

    button_debounce #(
        .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
    ) u_debounce_inc (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .btn_raw(btn[BTN_INC]),
        .press  (inc_press),
        .toggled()
    );

    assign hi_next = hi_cnt + HI_W'(inc_press);     // Wraps 3 to 0

    always_comb begin
        case ({toggled[BTN_ROT], toggled[BTN_DIR]})
            2'b00:   op_next = shifter_pkg::SHIFT_RIGHT;
            2'b01:   op_next = shifter_pkg::SHIFT_LEFT;
            2'b10:   op_next = shifter_pkg::ROTATE_RIGHT;
            default: op_next = shifter_pkg::ROTATE_LEFT;
        endcase
    end

    // Counter and toggles land on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_cnt <= '0;
            op     <= shifter_pkg::SHIFT_RIGHT;
            shamt  <= '0;
        end else begin
            hi_cnt <= hi_next;
            op     <= op_next;
            shamt  <= {hi_next, toggled[BTN_SH1], toggled[BTN_SH0]};
        end
    end

endmodule

`default_nettype wire

/* design/barrel_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]         data_in,
    input  shifter_pkg::shift_op_e   op,
    input  logic [$clog2(WIDTH)-1:0] shamt,
    output logic [WIDTH-1:0]         data_out
);

    localparam int STAGES = $clog2(WIDTH);

    logic [WIDTH-1:0] stage [0:STAGES];

    assign stage[0] = data_in;

    // Stage i moves by 2**i when its shamt bit is set
    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        localparam int AMT = 1 << i;

        always_comb begin
            if (!shamt[i]) begin
                stage[i+1] = stage[i];
            end else begin
                case (op)
                    shifter_pkg::SHIFT_LEFT:
                        stage[i+1] = stage[i] << AMT;
                    shifter_pkg::ROTATE_RIGHT:
                        stage[i+1] = {stage[i][AMT-1:0], stage[i][WIDTH-1:AMT]};
                    shifter_pkg::ROTATE_LEFT:
                        stage[i+1] = {stage[i][WIDTH-AMT-1:0], stage[i][WIDTH-1:WIDTH-AMT]};
                    default:
                        stage[i+1] = stage[i] >> AMT;       // Zero fill from the top
                endcase
            end
        end
    end

    assign data_out = stage[STAGES];

endmodule

`default_nettype wire

/* design/seg7_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

module seg7_scanner (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tick,
    input  logic [shifter_pkg::DATA_W-1:0]   value,
    output logic [display_pkg::SEG_W-1:0]    seg,
    output logic [display_pkg::DIGITS-1:0]   an
);

    localparam logic [2:0] LAST_DIGIT = 3'(display_pkg::SHOWN_DIGITS - 1);

    logic [2:0]                        digit_idx;
    logic                              active;
    logic                              show;
    logic [display_pkg::NIBBLE_W-1:0]  nibble;
    logic [display_pkg::SEG_W-1:0]     seg_next;
    logic [display_pkg::DIGITS-1:0]    an_next;

    assign show    = active | tick;     // Dark until the first tick
    assign nibble  = display_pkg::NIBBLE_W'(value >> (display_pkg::NIBBLE_W * digit_idx));
    assign an_next = ~(display_pkg::DIGITS'(1) << digit_idx);

    // Segments gfedcba, active low
    always_comb begin
        case (nibble)
            4'h0:    seg_next = 7'b1000000;
            4'h1:    seg_next = 7'b1111001;
            4'h2:    seg_next = 7'b0100100;
            4'h3:    seg_next = 7'b0110000;
            4'h4:    seg_next = 7'b0011001;
            4'h5:    seg_next = 7'b0010010;
            4'h6:    seg_next = 7'b0000010;
            4'h7:    seg_next = 7'b1111000;
            4'h8:    seg_next = 7'b0000000;
            4'h9:    seg_next = 7'b0010000;
            4'ha:    seg_next = 7'b0001000;
            4'hb:    seg_next = 7'b0000011;
            4'hc:    seg_next = 7'b1000110;
            4'hd:    seg_next = 7'b0100001;
            4'he:    seg_next = 7'b0000110;
            4'hf:    seg_next = 7'b0001110;
            default: seg_next = display_pkg::SEG_BLANK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_idx <= '0;
            active    <= 1'b0;
        end else if (tick) begin
            active    <= 1'b1;
            digit_idx <= (digit_idx == LAST_DIGIT) ? 3'd0 : digit_idx + 3'd1;
        end
    end

    // Upper four anodes never see a zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= display_pkg::SEG_BLANK;
            an  <= display_pkg::AN_OFF;
        end else if (show) begin
            seg <= seg_next;
            an  <= an_next;
        end
    end

endmodule

`default_nettype wire

/* design/shifter_display_top.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_top #(
    parameter int TICK_DIV       = 100000,
    parameter int DEBOUNCE_TICKS = 10
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [shifter_pkg::DATA_W-1:0]    sw,
    input  logic [shifter_pkg::BTN_COUNT-1:0] btn,
    output logic [display_pkg::SEG_W-1:0]     seg,
    output logic [display_pkg::DIGITS-1:0]    an,
    output shifter_pkg::shift_op_e            op,
    output logic [shifter_pkg::SHAMT_W-1:0]   shamt
);

    logic                           tick;
    logic [shifter_pkg::DATA_W-1:0] shifted;

    tick_divider #(
        .TICK_DIV(TICK_DIV)
    ) u_tick_divider (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    shift_control #(
        .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
    ) u_shift_control (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick),
        .btn  (btn),
        .op   (op),
        .shamt(shamt)
    );

    barrel_shifter #(
        .WIDTH(shifter_pkg::DATA_W)
    ) u_barrel_shifter (
        .data_in (sw),
        .op      (op),
        .shamt   (shamt),
        .data_out(shifted)
    );

    seg7_scanner u_seg7_scanner (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick),
        .value(shifted),
        .seg  (seg),
        .an   (an)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // Free running
    end

endmodule

`default_nettype wire

/* dv/shifter_display_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_assertions #(
    parameter bit CHECK_DISPLAY = 1'b1,
    parameter bit CHECK_CONTROL = 1'b1
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                tick,
    input logic [display_pkg::DIGITS-1:0]      an,
    input shifter_pkg::shift_op_e              op,
    input logic [shifter_pkg::SHAMT_W-1:0]     shamt
);

    if (CHECK_DISPLAY) begin : g_display
        // Digits 4 to 7 are never lit
        upper_digits_dark: assert property (@(posedge clk) disable iff (!rst_n)
            &an[display_pkg::DIGITS-1:display_pkg::SHOWN_DIGITS])
            else $error("an enabled one of the unused upper digits");

        one_digit_at_most: assert property (@(posedge clk) disable iff (!rst_n)
            $countones(~an) <= 1)
            else $error("an enabled more than one digit");
    end

    if (CHECK_CONTROL) begin : g_control
        op_known: assert property (@(posedge clk) disable iff (!rst_n)
            !$isunknown(op))
            else $error("op has an unknown value");

        // Toggles move on a tick edge, shamt one clock later
        shamt_after_tick: assert property (@(posedge clk) disable iff (!rst_n)
            $changed(shamt) |-> $past(tick, 2))
            else $error("shamt changed without a preceding tick");
    end

endmodule

bind seg7_scanner shifter_display_assertions #(
    .CHECK_DISPLAY(1'b1),
    .CHECK_CONTROL(1'b0)
) u_display_checks (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick),
    .an   (an),
    .op   (shifter_pkg::SHIFT_RIGHT),     // No op in the scanner
    .shamt(4'h0)
);

bind shift_control shifter_display_assertions #(
    .CHECK_DISPLAY(1'b0),
    .CHECK_CONTROL(1'b1)
) u_control_checks (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick),
    .an   (display_pkg::AN_OFF),          // No anodes in the control block
    .op   (op),
    .shamt(shamt)
);

`default_nettype wire

/* dv/shifter_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int TICK_DIV     = 4;
    localparam int DEB_TICKS    = 3;
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 16;
    localparam int HOLD_CYCLES  = (DEB_TICKS + 2) * TICK_DIV;   // Hold, then same time released
    localparam int PRESS_CYC    = 2 * HOLD_CYCLES;
    localparam int GLITCH_CYC   = TICK_DIV + HOLD_CYCLES;
    localparam int SCAN_CYC     = 2 * display_pkg::SHOWN_DIGITS * TICK_DIV;
    localparam int SWEEP_SETS   = 4 * 16;
    localparam int MAX_PRESSES  = N_RANDOM + 7 * SWEEP_SETS;    // Up to 4 toggles and 3 increments
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + MAX_PRESSES * PRESS_CYC
                                  + N_RANDOM * GLITCH_CYC + (N_RANDOM + SWEEP_SETS) * SCAN_CYC
                                  + 1000;

    // Segments gfedcba, active low
    localparam logic [6:0] HEX_SEG [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic                                clk;
    logic                                rst_n;
    logic [shifter_pkg::DATA_W-1:0]      sw;
    logic [shifter_pkg::BTN_COUNT-1:0]   btn;
    logic [display_pkg::SEG_W-1:0]      seg;
    logic [display_pkg::DIGITS-1:0]     an;
    shifter_pkg::shift_op_e              op;
    logic [shifter_pkg::SHAMT_W-1:0]     shamt;

    int       seed = 5;
    int       value_errors;
    int       other_errors;
    logic     exp_dir;      // Model of the toggles and the high counter
    logic     exp_rot;
    logic [1:0] exp_lo;
    logic [1:0] exp_hi;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    shifter_display_top #(
        .TICK_DIV      (TICK_DIV),
        .DEBOUNCE_TICKS(DEB_TICKS)
    ) UUT (
        .clk  (clk),
        .rst_n(rst_n),
        .sw   (sw),
        .btn  (btn),
        .seg  (seg),
        .an   (an),
        .op   (op),
        .shamt(shamt)
    );

    function automatic shifter_pkg::shift_op_e model_op();
        if (exp_rot) begin
            return exp_dir ? shifter_pkg::ROTATE_LEFT : shifter_pkg::ROTATE_RIGHT;
        end
        return exp_dir ? shifter_pkg::SHIFT_LEFT : shifter_pkg::SHIFT_RIGHT;
    endfunction

    function automatic logic [15:0] model_shift(input logic [15:0] d, input logic [3:0] amt);
        logic [15:0] lft;
        logic [15:0] rgt;
        lft = d << amt;
        rgt = d >> amt;
        if (!exp_rot) begin
            return exp_dir ? lft : rgt;
        end
        return exp_dir ? (lft | (d >> (16 - amt))) : (rgt | (d << (16 - amt)));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;     // Outputs settled, inputs move here
    endtask

    task automatic check_op(input shifter_pkg::shift_op_e exp);
        if (op !== exp) begin
            $display("** Error at %0t: op expected %s got %s", $time, exp.name(), op.name());
            value_errors++;
        end
    endtask

    task automatic check_shamt(input logic [shifter_pkg::SHAMT_W-1:0] exp);
        if (shamt !== exp) begin
            $display("** Error at %0t: shamt expected %0d got %0d", $time, exp, shamt);
            value_errors++;
        end
    endtask

    task automatic check_seg(input logic [display_pkg::SEG_W-1:0] exp, input int digit);
        if (seg !== exp) begin
            $display("** Error at %0t: seg digit %0d expected %b got %b",
                     $time, digit, exp, seg);
            value_errors++;
        end
    endtask

    task automatic check_an(input logic [display_pkg::DIGITS-1:0] exp);
        if (an !== exp) begin
            $display("** Error at %0t: an expected %b got %b", $time, exp, an);
            value_errors++;
        end
    endtask

    task automatic press_button(input int b);
        shifter_pkg::shift_op_e          old_op;
        logic [shifter_pkg::SHAMT_W-1:0] old_shamt;
        bit                              landed;
        old_op    = op;
        old_shamt = shamt;
        landed    = 1'b0;
        case (b)
            0:       exp_dir = ~exp_dir;
            1:       exp_rot = ~exp_rot;
            2:       exp_lo[0] = ~exp_lo[0];
            3:       exp_lo[1] = ~exp_lo[1];
            default: exp_hi = exp_hi + 2'd1;
        endcase
        btn[b] = 1'b1;
        for (int n = 0; n < PRESS_CYC; n++) begin
            if (n == HOLD_CYCLES) begin
                btn[b] = 1'b0;
            end
            next_cycle();
            if (op != old_op || shamt != old_shamt) begin
                landed = 1'b1;
            end
        end
        if (!landed) begin
            $display("Press of button %0d before %0t never changed op or shamt", b, $time);
            other_errors++;
        end else begin
            check_op(model_op());
            check_shamt({exp_hi, exp_lo});
        end
    endtask

    task automatic glitch_button(input int b, input int len);
        btn[b] = 1'b1;
        repeat (len) next_cycle();
        btn[b] = 1'b0;
        repeat (HOLD_CYCLES) next_cycle();
        check_op(model_op());
        check_shamt({exp_hi, exp_lo});
    endtask

    // seg follows the sw value that was applied before the edge
    task automatic scan_check();
        logic [15:0] res;
        logic [3:0]  seen;
        int          d;
        seen = '0;
        for (int n = 0; n < SCAN_CYC; n++) begin
            sw = shifter_pkg::DATA_W'($random(seed));
            next_cycle();
            res = model_shift(sw, {exp_hi, exp_lo});
            d = -1;
            for (int i = 0; i < display_pkg::SHOWN_DIGITS; i++) begin
                if (!an[i]) begin
                    d = i;
                end
            end
            if (d < 0) begin
                $display("No digit was enabled at %0t during the scan", $time);
                other_errors++;
            end else begin
                check_seg(HEX_SEG[res[4*d +: 4]], d);
                seen[d] = 1'b1;
            end
        end
        if (seen != 4'hf) begin
            $display("Scan ending at %0t skipped a digit, seen %b", $time, seen);
            other_errors++;
        end
    endtask

    task automatic set_state(input logic rot, input logic dir, input logic [3:0] amt);
        if (exp_dir != dir) press_button(0);
        if (exp_rot != rot) press_button(1);
        if (exp_lo[0] != amt[0]) press_button(2);
        if (exp_lo[1] != amt[1]) press_button(3);
        while (exp_hi != amt[3:2]) begin
            press_button(4);
        end
    endtask

    initial begin
        int b;
        value_errors = 0;
        other_errors = 0;
        exp_dir      = 1'b0;
        exp_rot      = 1'b0;
        exp_lo       = 2'b00;
        exp_hi       = 2'b00;
        rst_n        = 1'b0;
        sw           = '0;
        btn          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        next_cycle();
        check_an(display_pkg::AN_OFF);
        check_seg(display_pkg::SEG_BLANK, 0);
        check_op(shifter_pkg::SHIFT_RIGHT);
        check_shamt('0);

        for (int i = 0; i < N_RANDOM; i++) begin
            b = $unsigned($random(seed)) % shifter_pkg::BTN_COUNT;
            press_button(b);
            b = $unsigned($random(seed)) % shifter_pkg::BTN_COUNT;
            glitch_button(b, 1 + $unsigned($random(seed)) % (TICK_DIV - 1));
            scan_check();
        end

        // Every op with every shift amount
        for (int o = 0; o < 4; o++) begin
            for (int s = 0; s < 16; s++) begin
                set_state(o[1], o[0], 4'(s));
                scan_check();
            end
        end

        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests ended", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/shifter_pkg.sv
design/display_pkg.sv
design/tick_divider.sv
design/button_debounce.sv
design/shift_control.sv
design/barrel_shifter.sv
design/seg7_scanner.sv
design/shifter_display_top.sv
dv/tb_clock.sv
dv/shifter_display_assertions.sv
dv/shifter_display_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = shifter_display_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "exit status 0" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
